/* list.f */
source/isa_pkg.sv
source/core_pkg.sv
source/instr_queue.sv
source/decode_issue.sv
source/register_file.sv
source/alu_execute.sv
source/alu_core.sv
tests/alu_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ALU core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module alu_core_tb \
    -f list.f -o alu_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build error, see build.log"
    exit 1
fi

./obj_dir/alu_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

/* source/alu_core.sv */
//////////////////////////////////////////////////////////////////////
// ALU core top level
// Queue, decode/issue, register file and execute pipeline
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  isa_pkg::instr_t          in_instr,
    output logic                     in_credit,
    input  logic                     out_credit,
    output logic                     out_valid,
    output core_pkg::commit_packet_t out_commit
);

    logic                     q_valid;
    isa_pkg::instr_t          q_instr;
    logic                     q_pop;
    isa_pkg::reg_idx_t        rs1_addr;
    isa_pkg::reg_idx_t        rs2_addr;
    isa_pkg::word_t           rs1_data;
    isa_pkg::word_t           rs2_data;
    core_pkg::issue_packet_t  issue;
    core_pkg::commit_packet_t ex_fwd;
    core_pkg::commit_packet_t commit;

    instr_queue i_instr_queue (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_credit (in_credit),
        .q_valid   (q_valid),
        .q_instr   (q_instr),
        .q_pop     (q_pop)
    );

    decode_issue i_decode_issue (
        .clk        (clk),
        .reset      (reset),
        .q_valid    (q_valid),
        .q_instr    (q_instr),
        .q_pop      (q_pop),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_fwd     (ex_fwd),
        .commit     (commit),
        .out_credit (out_credit),
        .issue      (issue)
    );

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .commit   (commit)
    );

    alu_execute i_alu_execute (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .ex_fwd (ex_fwd),
        .commit (commit)
    );

    // Commit port
    assign out_valid  = commit.valid;
    assign out_commit = commit;

endmodule

`default_nettype wire

/* source/alu_execute.sv */
//////////////////////////////////////////////////////////////////////
// ALU execute and writeback
// One-cycle ALU, registered commit record
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  logic                     clk,
    input  logic                     reset,
    input  core_pkg::issue_packet_t  issue,
    output core_pkg::commit_packet_t ex_fwd,
    output core_pkg::commit_packet_t commit
);

    isa_pkg::word_t result;
    logic [4:0]     shamt;

    assign shamt = issue.op_b[4:0];

    always_comb begin
        case (issue.func)
            isa_pkg::ALU_ADD:  result = issue.op_a + issue.op_b;
            isa_pkg::ALU_SUB:  result = issue.op_a - issue.op_b;
            isa_pkg::ALU_SLL:  result = issue.op_a << shamt;
            isa_pkg::ALU_SLT:  result = isa_pkg::word_t'($signed(issue.op_a) < $signed(issue.op_b));
            isa_pkg::ALU_SLTU: result = isa_pkg::word_t'(issue.op_a < issue.op_b);
            isa_pkg::ALU_XOR:  result = issue.op_a ^ issue.op_b;
            isa_pkg::ALU_SRL:  result = issue.op_a >> shamt;
            isa_pkg::ALU_SRA:  result = isa_pkg::word_t'($signed(issue.op_a) >>> shamt);
            isa_pkg::ALU_OR:   result = issue.op_a | issue.op_b;
            isa_pkg::ALU_AND:  result = issue.op_a & issue.op_b;
            default:           result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Forwarding view of the executing instruction
    always_comb begin
        ex_fwd.valid     = issue.valid;
        ex_fwd.rd        = issue.rd;
        // x0 never written
        ex_fwd.writes_rd = issue.writes_rd && (issue.rd != '0);
        ex_fwd.illegal   = issue.illegal;
        // Illegal records carry a zero result
        ex_fwd.result    = issue.illegal ? '0 : result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit <= '0;
        end else begin
            commit <= ex_fwd;
        end
    end

    // Commits never write x0 and illegal ones write nothing
    assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> !(commit.writes_rd && (commit.rd == '0 || commit.illegal)))
        else $error("commit record writes x0 or comes from an illegal instruction");

endmodule

`default_nettype wire

/* source/core_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Core pipeline definitions
// Queue and credit sizes, stage-to-stage packets
//////////////////////////////////////////////////////////////////////
`default_nettype none

package core_pkg;

    // Input credits after reset equal the queue depth
    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 4;

    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count_t;
    typedef logic [$clog2(OUT_CREDITS+1)-1:0] out_credit_t;

    // Decode to execute
    typedef struct packed {
        logic               valid;
        isa_pkg::alu_func_e func;
        isa_pkg::reg_idx_t  rd;
        logic               writes_rd;
        logic               illegal;
        isa_pkg::word_t     op_a;
        isa_pkg::word_t     op_b;
    } issue_packet_t;

    // Execute to register file, forwarding and commit port
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        logic              writes_rd;
        logic              illegal;
        isa_pkg::word_t    result;
    } commit_packet_t;

endpackage

`default_nettype wire

/* source/decode_issue.sv */
//////////////////////////////////////////////////////////////////////
// Decode and issue
// Operand read with forwarding, issue gated by commit credits
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_issue (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     q_valid,
    input  isa_pkg::instr_t          q_instr,
    output logic                     q_pop,
    output isa_pkg::reg_idx_t        rs1_addr,
    output isa_pkg::reg_idx_t        rs2_addr,
    input  isa_pkg::word_t           rs1_data,
    input  isa_pkg::word_t           rs2_data,
    input  core_pkg::commit_packet_t ex_fwd,
    input  core_pkg::commit_packet_t commit,
    input  logic                     out_credit,
    output core_pkg::issue_packet_t  issue
);

    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  is_op;
    logic                  alt;
    logic                  illegal;
    logic                  use_imm;
    isa_pkg::word_t        imm;
    isa_pkg::alu_func_e    func;
    core_pkg::out_credit_t credits;
    logic                  issue_fire;

    // Youngest producer wins
    function automatic isa_pkg::word_t forward(
        input isa_pkg::reg_idx_t        addr,
        input isa_pkg::word_t           rf_data,
        input core_pkg::commit_packet_t ex,
        input core_pkg::commit_packet_t cm
    );
        if (ex.valid && ex.writes_rd && ex.rd == addr) begin
            return ex.result;
        end else if (cm.valid && cm.writes_rd && cm.rd == addr) begin
            return cm.result;
        end
        return rf_data;
    endfunction

    assign funct3   = q_instr[14:12];
    assign funct7   = q_instr[31:25];
    assign rs1_addr = q_instr[19:15];
    assign rs2_addr = q_instr[24:20];
    assign is_op    = (q_instr[6:0] == isa_pkg::OP);
    assign alt      = (funct7 == isa_pkg::F7_ALT);

    always_comb begin
        case (funct3)
            isa_pkg::F3_ADD_SUB: func = (is_op && alt) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     func = isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     func = isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    func = isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     func = isa_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: func = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:      func = isa_pkg::ALU_OR;
            default:             func = isa_pkg::ALU_AND;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Legality and immediate
    always_comb begin
        illegal = 1'b0;
        use_imm = 1'b0;
        imm     = isa_pkg::word_t'($signed(q_instr[31:20]));
        case (q_instr[6:0])
            isa_pkg::OP: begin
                illegal = !(funct7 == isa_pkg::F7_BASE ||
                            (alt && (funct3 == isa_pkg::F3_ADD_SUB ||
                                     funct3 == isa_pkg::F3_SRL_SRA)));
            end
            isa_pkg::OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == isa_pkg::F3_SLL) begin
                    illegal = (funct7 != isa_pkg::F7_BASE);
                    imm     = isa_pkg::word_t'(q_instr[24:20]);
                end else if (funct3 == isa_pkg::F3_SRL_SRA) begin
                    illegal = !(funct7 == isa_pkg::F7_BASE || alt);
                    imm     = isa_pkg::word_t'(q_instr[24:20]);
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Issue and commit credits
    assign issue_fire = q_valid && (credits != '0);
    assign q_pop      = issue_fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue <= '0;
        end else begin
            issue.valid     <= issue_fire;
            issue.func      <= func;
            issue.rd        <= q_instr[11:7];
            issue.writes_rd <= !illegal;
            issue.illegal   <= illegal;
            issue.op_a      <= forward(rs1_addr, rs1_data, ex_fwd, commit);
            issue.op_b      <= use_imm ? imm : forward(rs2_addr, rs2_data, ex_fwd, commit);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= core_pkg::out_credit_t'(core_pkg::OUT_CREDITS);
        end else if (issue_fire && !out_credit) begin
            credits <= credits - core_pkg::out_credit_t'(1);
        end else if (!issue_fire && out_credit) begin
            credits <= credits + core_pkg::out_credit_t'(1);
        end
    end

    // Consumer returns no more credits than records it was given
    assert property (@(posedge clk) disable iff (reset)
        credits <= core_pkg::out_credit_t'(core_pkg::OUT_CREDITS))
        else $error("commit credit count above its initial grant");

endmodule

`default_nettype wire

/* source/instr_queue.sv */
//////////////////////////////////////////////////////////////////////
// Instruction queue
// Circular FIFO that hands one credit back per freed entry
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  isa_pkg::instr_t in_instr,
    output logic            in_credit,
    output logic            q_valid,
    output isa_pkg::instr_t q_instr,
    input  logic            q_pop
);

    typedef logic [$clog2(core_pkg::QUEUE_DEPTH)-1:0] ptr_t;

    isa_pkg::instr_t        entries [core_pkg::QUEUE_DEPTH];
    ptr_t                   wr_ptr;
    ptr_t                   rd_ptr;
    core_pkg::queue_count_t count;
    logic                   full;
    logic                   push;
    logic                   pop;

    assign full = (count == core_pkg::queue_count_t'(core_pkg::QUEUE_DEPTH));
    assign push = in_valid && !full;
    assign pop  = q_pop && q_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + core_pkg::queue_count_t'(1);
                2'b01:   count <= count - core_pkg::queue_count_t'(1);
                default: count <= count;
            endcase
            // Freed slot goes back to the producer a cycle later
            in_credit <= pop;
        end
    end

    // Head entry
    assign q_valid = (count != '0);
    assign q_instr = entries[rd_ptr];

    // Producer must respect its credits
    assert property (@(posedge clk) disable iff (reset) !(in_valid && full))
        else $error("instruction sent to a full queue");

endmodule

`default_nettype wire

/* source/isa_pkg.sv */
//////////////////////////////////////////////////////////////////////
// RV32I integer subset
// Field widths, opcodes and ALU function encodings
//////////////////////////////////////////////////////////////////////
`default_nettype none

package isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    // Only the two integer ALU major opcodes are decoded
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    // funct3 field
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 field, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_func_e;

endpackage

`default_nettype wire

/* source/register_file.sv */
//////////////////////////////////////////////////////////////////////
// Integer register file
// 31 writable registers, x0 reads as zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                     clk,
    input  logic                     reset,
    input  isa_pkg::reg_idx_t        rs1_addr,
    input  isa_pkg::reg_idx_t        rs2_addr,
    output isa_pkg::word_t           rs1_data,
    output isa_pkg::word_t           rs2_data,
    input  core_pkg::commit_packet_t commit
);

    isa_pkg::word_t regs [1:isa_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.writes_rd && commit.rd != '0) begin
            regs[commit.rd] <= commit.result;
        end
    end

    // Same-cycle writes are covered by forwarding in decode
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* tests/alu_core_tb.sv */
//////////////////////////////////////////////////////////////////////
// ALU core testbench
// Credit-based producer and consumer, RV32I reference model, assertions
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_core_tb;

    localparam int         MAX_RECORDS = 256;
    localparam logic [6:0] OPC_REG     = 7'b0110011;
    localparam logic [6:0] OPC_IMM     = 7'b0010011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     in_valid;
    isa_pkg::instr_t          in_instr;
    logic                     in_credit;
    logic                     out_credit;
    logic                     out_valid;
    core_pkg::commit_packet_t out_commit;

    isa_pkg::word_t           ref_regs [isa_pkg::NUM_REGS];
    core_pkg::commit_packet_t exp_mem [MAX_RECORDS];
    core_pkg::commit_packet_t exp_head;
    int                       exp_wr       = 0;
    int                       exp_rd       = 0;
    int                       sent_count   = 0;
    int                       credits_back = 0;
    int                       ret_count    = 0;
    int                       cycle_count  = 0;
    logic                     withhold     = 1'b0;
    int unsigned              seed_val;

    always #10 clk = ~clk;

    alu_core i_alu_core (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_commit (out_commit)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("FAIL %0t %s expected %h actual %h",
                                $time, name, expected, actual));
    endtask

    function automatic isa_pkg::reg_idx_t pick_reg(input int lo, input int hi);
        return isa_pkg::reg_idx_t'($urandom_range(hi, lo));
    endfunction

    function automatic isa_pkg::instr_t encode_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic isa_pkg::instr_t encode_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model, one record per instruction in program order
    task automatic predict_commit(input isa_pkg::instr_t instr);
        core_pkg::commit_packet_t rec;
        logic [6:0]               opcode;
        logic [6:0]               funct7;
        logic [2:0]               funct3;
        isa_pkg::word_t           a;
        isa_pkg::word_t           b;
        logic                     legal;
        opcode = instr[6:0];
        funct7 = instr[31:25];
        funct3 = instr[14:12];
        a      = ref_regs[instr[19:15]];
        // Second operand or sign-extended immediate
        b      = (opcode == OPC_REG) ? ref_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        if (opcode == OPC_REG) begin
            legal = funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
        end else if (opcode == OPC_IMM) begin
            legal = (funct3 == 3'd1) ? (funct7 == 7'h00) :
                    (funct3 == 3'd5) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;
        end else begin
            legal = 1'b0;
        end
        rec = '0;
        case (funct3)
            3'd0: rec.result = (opcode == OPC_REG && funct7[5]) ? a - b : a + b;
            3'd1: rec.result = a << b[4:0];
            3'd2: rec.result = {31'b0, $signed(a) < $signed(b)};
            3'd3: rec.result = {31'b0, a < b};
            3'd4: rec.result = a ^ b;
            3'd5: begin
                if (funct7[5]) begin
                    rec.result = $signed(a) >>> b[4:0];
                end else begin
                    rec.result = a >> b[4:0];
                end
            end
            3'd6: rec.result = a | b;
            default: rec.result = a & b;
        endcase
        rec.valid     = 1'b1;
        rec.rd        = instr[11:7];
        rec.illegal   = !legal;
        rec.writes_rd = legal && instr[11:7] != 5'd0;
        if (rec.writes_rd) begin
            ref_regs[rec.rd] = rec.result;
        end
        exp_mem[exp_wr] = rec;
        exp_wr++;
    endtask

    // Waits for an input credit, then drives one instruction for a cycle
    task automatic send_instr(input isa_pkg::instr_t instr);
        while (sent_count - credits_back >= core_pkg::QUEUE_DEPTH) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_instr = instr;
        sent_count++;
        predict_commit(instr);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    assign exp_head = exp_mem[exp_rd];

    always @(posedge clk) begin
        if (!reset && out_valid) begin
            exp_rd <= exp_rd + 1;
        end
        if (!reset && in_credit) begin
            credits_back <= credits_back + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > 40 * sent_count + 200) begin
            stop_on_error("timeout: the expected commit records did not all arrive");
        end
    end

    // Consumer, returns a credit most cycles and holds it now and then
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (!reset && !withhold && exp_rd > ret_count && $urandom_range(0, 3) != 0) begin
                out_credit = 1'b1;
                ret_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks on the commit port and both credit loops
    assert property (@(posedge clk) disable iff (reset) out_valid |-> exp_rd < exp_wr)
        else stop_on_error("commit record arrived with no instruction left to expect");
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_commit.illegal == exp_head.illegal)
        else report_mismatch("out_commit.illegal", 32'($sampled(exp_head.illegal)),
                             32'($sampled(out_commit.illegal)));
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_commit.writes_rd == exp_head.writes_rd)
        else report_mismatch("out_commit.writes_rd", 32'($sampled(exp_head.writes_rd)),
                             32'($sampled(out_commit.writes_rd)));
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_commit.rd == exp_head.rd)
        else report_mismatch("out_commit.rd", 32'($sampled(exp_head.rd)),
                             32'($sampled(out_commit.rd)));
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !exp_head.illegal |-> out_commit.result == exp_head.result)
        else report_mismatch("out_commit.result", $sampled(exp_head.result),
                             $sampled(out_commit.result));
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> exp_rd - ret_count < core_pkg::OUT_CREDITS)
        else stop_on_error("out_valid beyond the commit credits granted");
    assert property (@(posedge clk) disable iff (reset) in_credit |-> credits_back < sent_count)
        else stop_on_error("in_credit pulse with no instruction outstanding");

    initial begin
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        seed_val = $urandom(32'h9ed5);
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        reset    = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Random operands through dependent ADDI, SLLI, XORI chains
        for (int r = 1; r <= 8; r++) begin
            send_instr(encode_imm(12'($urandom), 5'd0, 3'd0, 5'(r)));
            send_instr(encode_imm(12'd20, 5'(r), 3'd1, 5'(r)));
            send_instr(encode_imm(12'($urandom), 5'(r), 3'd4, 5'(r)));
        end

        // Every register-register function, then random ones
        for (int k = 0; k < 8; k++) begin
            send_instr(encode_reg(7'h00, pick_reg(1, 8), pick_reg(1, 8), 3'(k), pick_reg(9, 15)));
        end
        send_instr(encode_reg(7'h20, 5'd2, 5'd1, 3'd0, 5'd9));
        send_instr(encode_reg(7'h20, 5'd4, 5'd3, 3'd5, 5'd10));
        repeat (12) begin
            f3 = 3'($urandom);
            f7 = 7'h00;
            if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) begin
                f7 = 7'h20;
            end
            send_instr(encode_reg(f7, pick_reg(1, 31), pick_reg(1, 31), f3, pick_reg(9, 31)));
        end

        // Immediates, negative ones and all three shifts
        send_instr(encode_imm(12'hfff, 5'd1, 3'd0, 5'd16));
        send_instr(encode_imm(12'h800, 5'd2, 3'd2, 5'd17));
        send_instr(encode_imm(12'hffb, 5'd3, 3'd3, 5'd18));
        send_instr(encode_imm(12'h41f, 5'd4, 3'd5, 5'd19));
        send_instr(encode_imm(12'h007, 5'd5, 3'd5, 5'd20));
        send_instr(encode_imm(12'h01f, 5'd6, 3'd1, 5'd21));
        repeat (12) begin
            f3 = 3'($urandom);
            if (f3 == 3'd1) begin
                imm = {7'h00, 5'($urandom)};
            end else if (f3 == 3'd5) begin
                imm = {($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00, 5'($urandom)};
            end else begin
                imm = 12'($urandom);
            end
            send_instr(encode_imm(imm, pick_reg(1, 15), f3, pick_reg(16, 31)));
        end

        // Back-to-back dependents, forwarded from execute and commit
        send_instr(encode_reg(7'h00, 5'd2, 5'd1, 3'd0, 5'd22));
        send_instr(encode_reg(7'h20, 5'd3, 5'd22, 3'd0, 5'd23));
        send_instr(encode_reg(7'h00, 5'd22, 5'd23, 3'd4, 5'd24));
        send_instr(encode_reg(7'h00, 5'd23, 5'd24, 3'd6, 5'd25));

        // Write to x0, then read it back
        send_instr(encode_imm(12'h123, 5'd1, 3'd0, 5'd0));
        send_instr(encode_reg(7'h00, 5'd1, 5'd0, 3'd0, 5'd26));

        // Load, MUL and SLLI with a bad funct7, then their destinations read
        send_instr({12'h004, 5'd1, 3'd2, 5'd5, OPC_LOAD});
        send_instr(encode_reg(7'h01, 5'd2, 5'd1, 3'd0, 5'd6));
        send_instr(encode_imm(12'h401, 5'd1, 3'd1, 5'd7));
        send_instr(encode_reg(7'h00, 5'd6, 5'd5, 3'd0, 5'd27));
        send_instr(encode_reg(7'h00, 5'd7, 5'd0, 3'd6, 5'd28));

        // Commit credits withheld while the producer keeps sending
        withhold = 1'b1;
        fork
            begin
                for (int k = 0; k < 12; k++) begin
                    send_instr(encode_reg(7'h00, pick_reg(1, 31), pick_reg(1, 31), 3'(k),
                                          pick_reg(1, 31)));
                end
            end
            begin
                repeat (30) @(posedge clk);
                #1;
                withhold = 1'b0;
            end
        join

        while (exp_rd != exp_wr) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        if (credits_back == sent_count) begin
            $display("test passed");
            $finish;
        end else begin
            stop_on_error("input credits were not all returned after the last commit");
        end
    end

endmodule

`default_nettype wire
